//--- vlog.f
+incdir+include
rtl/joybus_pkg.sv
rtl/response_builder.sv
rtl/data_crc_unit.sv
rtl/line_encoder.sv
rtl/joybus_responder.sv
sim/joybus_responder_asserts.sv
sim/tb_joybus_responder.sv

//--- Makefile
# Verilator build for the Joybus responder testbench

VERILATOR  ?= verilator
TOP        := tb_joybus_responder
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits with a failing status on $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_joybus_responder.sv
`timescale 1ns/1ps
`include "joybus_macros.svh"

module tb_joybus_responder import joybus_pkg::*; ();

    localparam int level_w        = int'(`JB_LEVEL_WIDTH);
    localparam int bit_w          = int'(`JB_BIT_WIDTH);
    localparam int sample_phase   = level_w + level_w / 2;  // middle of the second level
    localparam int info_latency   = 203;
    localparam int status_latency = 267;
    localparam int write_latency  = 84;
    localparam int silent_cycles  = 300;
    localparam int hold_cycles    = 100;
    // tests take about 2500 cycles in total
    localparam int timeout_cycles = 3000;

    logic       sample_clk;
    logic       crc_reset;
    logic       cur_operation;
    logic [7:0] cmd;
    logic [7:0] crc;
    pad_state_t pad;
    logic       data_tx;
    logic       data_oe;
    logic       rx_handoff;

    int          cycle_cnt = 0;
    logic        oe_q      = 1'b0;
    int          bit_phase = 0;     // clocks into the current bit on the line
    int          rx_count  = 0;     // bits decoded in the last frame, stop bit included
    int          frame_cnt = 0;
    logic [63:0] rx_bits   = '0;    // last decoded bit in bit 0

    joybus_responder dut0 (
        .sample_clk    (sample_clk),
        .crc_reset     (crc_reset),
        .cur_operation (cur_operation),
        .cmd           (cmd),
        .crc           (crc),
        .pad           (pad),
        .data_tx       (data_tx),
        .data_oe       (data_oe),
        .rx_handoff    (rx_handoff)
    );

    initial begin
        sample_clk = 1'b0;
        forever #50 sample_clk = ~sample_clk;
    end

    always @(posedge sample_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Simulation failed");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    always @(negedge sample_clk) begin
        if (dut0.asserts0.fail_cnt != 0) begin
            $display("a concurrent assertion on the DUT failed");
            $display("Simulation failed");
            $fatal(1, "stopped by a failed assertion");
        end
    end

    // line decoder, outputs settle on the rising edge so sample on the falling one
    always @(negedge sample_clk) begin
        oe_q <= data_oe;
        if (!data_oe) begin
            bit_phase <= 0;
        end else begin
            if (!oe_q) begin
                frame_cnt <= frame_cnt + 1;     // line just taken
                rx_count  <= 0;
                rx_bits   <= '0;
            end else if (bit_phase == sample_phase) begin
                rx_bits  <= {rx_bits[62:0], data_tx};
                rx_count <= rx_count + 1;
            end
            bit_phase <= (bit_phase == bit_w - 1) ? 0 : bit_phase + 1;
        end
    end

    // write ack byte as seed times x^8 modulo the full CRC polynomial
    function automatic logic [7:0] crc_flush_model(input logic [7:0] seed);
        logic [15:0] dividend;
        logic [8:0]  divisor;
        int          i;
        dividend = {seed, 8'h00};
        divisor  = {1'b1, `JB_CRC_POLY};
        for (i = 15; i >= 8; i--) begin
            if (dividend[i]) begin
                dividend = dividend ^ (16'(divisor) << (i - 8));
            end
        end
        return dividend[7:0];
    endfunction

    task automatic report_mismatch(input string test_name, input string what,
                                   input logic [63:0] expected, input logic [63:0] actual);
        $display("error %s %s: expected 0x%0h, actual 0x%0h", test_name, what,
                 expected, actual);
        $display("Simulation failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic raise_operation(input logic [7:0] code);
        @(negedge sample_clk);
        cmd           = code;
        cur_operation = 1'b1;
    endtask

    task automatic release_operation();
        @(negedge sample_clk);
        cur_operation = 1'b0;
        repeat (2) @(negedge sample_clk);
    endtask

    // line stays released and quiet while the operation is held
    task automatic hold_silent(input string test_name, input int cycles);
        logic h0;
        int   f0;
        h0 = rx_handoff;
        f0 = frame_cnt;
        repeat (cycles) begin
            @(negedge sample_clk);
            assert (!data_oe)
                else report_mismatch(test_name, "data_oe", 64'd0, 64'(data_oe));
            assert (rx_handoff == h0)
                else report_mismatch(test_name, "rx_handoff", 64'(h0), 64'(rx_handoff));
        end
        assert (frame_cnt == f0)
            else report_mismatch(test_name, "frames", 64'(f0), 64'(frame_cnt));
    endtask

    task automatic respond_and_check(input string test_name, input logic [7:0] code,
                                     input logic [31:0] exp_word, input int exp_len,
                                     input int exp_lat);
        int          t0;
        int          f0;
        int          waited;
        logic        h0;
        logic [63:0] mask;
        logic [31:0] got_word;
        raise_operation(code);
        h0     = rx_handoff;
        t0     = cycle_cnt;
        f0     = frame_cnt;
        waited = 0;
        while (rx_handoff == h0) begin
            @(negedge sample_clk);
            waited++;
            if (waited == 12) begin
                pad = pad_state_t'(~pad);   // answer was captured at start
                crc = ~crc;
            end
        end
        mask     = (64'd1 << exp_len) - 64'd1;
        got_word = 32'((rx_bits >> 1) & mask);
        assert (cycle_cnt - t0 == exp_lat)
            else report_mismatch(test_name, "latency", 64'(exp_lat), 64'(cycle_cnt - t0));
        assert (frame_cnt == f0 + 1)
            else report_mismatch(test_name, "frames", 64'(f0 + 1), 64'(frame_cnt));
        assert (rx_count == exp_len + 1)
            else report_mismatch(test_name, "bit count", 64'(exp_len + 1), 64'(rx_count));
        assert (got_word == exp_word)
            else report_mismatch(test_name, "data", 64'(exp_word), 64'(got_word));
        assert (rx_bits[0] == 1'b0)
            else report_mismatch(test_name, "stop bit", 64'd0, 64'(rx_bits[0]));
        assert (!data_oe && data_tx)
            else report_mismatch(test_name, "idle line", 64'h1, 64'({data_oe, data_tx}));
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] exp_word;
        logic [7:0]  seed;
        int          n;
        crc_reset     = 1'b1;
        cur_operation = 1'b0;
        cmd           = 8'h00;
        crc           = 8'h00;
        pad           = '0;
        void'($urandom(63));
        repeat (2) @(posedge sample_clk);
        @(negedge sample_clk);
        crc_reset = 1'b0;

        @(negedge sample_clk);
        assert (rx_handoff == 1'b0)
            else report_mismatch("reset", "rx_handoff", 64'd0, 64'(rx_handoff));
        assert (data_oe == 1'b0)
            else report_mismatch("reset", "data_oe", 64'd0, 64'(data_oe));
        assert (data_tx == 1'b1)
            else report_mismatch("reset", "data_tx", 64'd1, 64'(data_tx));

        // identification word for both info codes
        respond_and_check("info_00", 8'h00, {8'h00, `JB_INFO_ID}, 24, info_latency);
        release_operation();
        respond_and_check("info_ff", 8'hff, {8'h00, `JB_INFO_ID}, 24, info_latency);
        release_operation();

        for (n = 0; n < 2; n++) begin
            rnd         = $urandom;
            pad.buttons = rnd[15:0];
            pad.stick_x = rnd[23:16];
            pad.stick_y = rnd[31:24];
            exp_word    = {pad.buttons, pad.stick_x, pad.stick_y};
            respond_and_check($sformatf("status_%0d", n), 8'h01, exp_word, 32,
                              status_latency);
            release_operation();
        end

        for (n = 0; n < 3; n++) begin
            rnd  = $urandom;
            seed = rnd[7:0];
            crc  = seed;
            respond_and_check($sformatf("write_%0d", n), 8'h03,
                              {24'h000000, crc_flush_model(seed)}, 8, write_latency);
            release_operation();
        end

        // read and an undefined code get no answer
        raise_operation(8'h02);
        hold_silent("silent_read", silent_cycles);
        release_operation();
        raise_operation(8'h5a);
        hold_silent("silent_unknown", silent_cycles);
        release_operation();

        // one frame per operation, a new one only after the level drops
        rnd         = $urandom;
        pad.buttons = rnd[15:0];
        pad.stick_x = rnd[23:16];
        pad.stick_y = rnd[31:24];
        exp_word    = {pad.buttons, pad.stick_x, pad.stick_y};
        respond_and_check("one_per_op", 8'h01, exp_word, 32, status_latency);
        hold_silent("one_per_op_hold", hold_cycles);
        release_operation();
        rnd         = $urandom;
        pad.buttons = rnd[15:0];
        pad.stick_x = rnd[23:16];
        pad.stick_y = rnd[31:24];
        exp_word    = {pad.buttons, pad.stick_x, pad.stick_y};
        respond_and_check("one_per_op_again", 8'h01, exp_word, 32, status_latency);
        release_operation();

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- sim/joybus_responder_asserts.sv
`timescale 1ns/1ps
`include "joybus_macros.svh"

module joybus_responder_asserts (
    input logic       sample_clk,
    input logic       crc_reset,
    input logic       start,
    input logic [7:0] cmd,
    input logic       data_tx,
    input logic       data_oe,
    input logic       rx_handoff
);
    localparam int bit_w          = int'(`JB_BIT_WIDTH);
    localparam int frame_extra    = 3;      // first level delay, stop tail, toggle
    localparam int crc_delay      = 9;      // seed load and eight zero shifts
    localparam int info_latency   = (24 + 1) * bit_w + frame_extra;
    localparam int status_latency = (32 + 1) * bit_w + frame_extra;
    localparam int write_latency  = (8 + 1) * bit_w + frame_extra + crc_delay;

    logic       handoff_q;
    logic       pending;                    // answered start seen, handoff still due
    logic [3:0] bit_phase;                  // clocks into the bit on the line
    logic       answers;                    // command code that gets a frame
    int         fail_cnt = 0;

    assign answers = (cmd == 8'h00) || (cmd == 8'h01) || (cmd == 8'h03) || (cmd == 8'hff);

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            handoff_q <= 1'b0;
            pending   <= 1'b0;
            bit_phase <= '0;
        end else begin
            handoff_q <= rx_handoff;
            if (start && answers) begin
                pending <= 1'b1;
            end else if (rx_handoff != handoff_q) begin
                pending <= 1'b0;
            end
            if (!data_oe) begin
                bit_phase <= '0;
            end else begin
                bit_phase <= (bit_phase == `JB_BIT_WIDTH - 4'd1) ? 4'd0 : bit_phase + 4'd1;
            end
        end
    end

    a_handoff_after_start: assert property (@(posedge sample_clk) disable iff (crc_reset)
        (rx_handoff != handoff_q) |-> pending)
        else begin
            $error("rx_handoff toggled with no start before it");
            fail_cnt++;
        end

    a_first_level_low: assert property (@(posedge sample_clk) disable iff (crc_reset)
        (data_oe && bit_phase < 4'(`JB_LEVEL_WIDTH)) |-> !data_tx)
        else begin
            $error("first level of a bit is not low");
            fail_cnt++;
        end

    a_idle_released: assert property (@(posedge sample_clk) disable iff (crc_reset)
        !pending |-> !data_oe)
        else begin
            $error("line driven while the responder is idle");
            fail_cnt++;
        end

    a_info_latency: assert property (@(posedge sample_clk) disable iff (crc_reset)
        start && (cmd == 8'h00 || cmd == 8'hff) |-> ##info_latency $changed(rx_handoff))
        else begin
            $error("info handoff not %0d cycles after start", info_latency);
            fail_cnt++;
        end

    a_status_latency: assert property (@(posedge sample_clk) disable iff (crc_reset)
        start && cmd == 8'h01 |-> ##status_latency $changed(rx_handoff))
        else begin
            $error("status handoff not %0d cycles after start", status_latency);
            fail_cnt++;
        end

    a_write_latency: assert property (@(posedge sample_clk) disable iff (crc_reset)
        start && cmd == 8'h03 |-> ##write_latency $changed(rx_handoff))
        else begin
            $error("write handoff not %0d cycles after start", write_latency);
            fail_cnt++;
        end

endmodule

bind joybus_responder joybus_responder_asserts asserts0 (
    .sample_clk (sample_clk),
    .crc_reset  (crc_reset),
    .start      (start),
    .cmd        (cmd),
    .data_tx    (data_tx),
    .data_oe    (data_oe),
    .rx_handoff (rx_handoff)
);

//--- rtl/joybus_responder.sv
`timescale 1ns/1ps

module joybus_responder import joybus_pkg::*; (
    input  logic       sample_clk,
    input  logic       crc_reset,
    input  logic       cur_operation,
    input  logic [7:0] cmd,
    input  logic [7:0] crc,
    input  pad_state_t pad,
    output logic       data_tx,
    output logic       data_oe,
    output logic       rx_handoff
);
    logic        start;         // one pulse per operation
    resp_t       resp;
    crc_result_t crc_result;

    // word and length for the command
    response_builder builder0 (
        .sample_clk (sample_clk),
        .crc_reset  (crc_reset),
        .start      (start),
        .cmd        (cmd),
        .pad        (pad),
        .resp       (resp)
    );

    // write ack byte, flushed from the seed
    data_crc_unit crc0 (
        .sample_clk (sample_clk),
        .crc_reset  (crc_reset),
        .start      (start),
        .crc        (crc),
        .result     (crc_result)
    );

    // picks word or crc, drives the line
    line_encoder encoder0 (
        .sample_clk    (sample_clk),
        .crc_reset     (crc_reset),
        .cur_operation (cur_operation),
        .resp          (resp),
        .crc_result    (crc_result),
        .start         (start),
        .data_tx       (data_tx),
        .data_oe       (data_oe),
        .rx_handoff    (rx_handoff)
    );

endmodule

//--- rtl/line_encoder.sv
`timescale 1ns/1ps
`include "joybus_macros.svh"

module line_encoder import joybus_pkg::*; (
    input  logic        sample_clk,
    input  logic        crc_reset,
    input  logic        cur_operation,
    input  resp_t       resp,
    input  crc_result_t crc_result,
    output logic        start,
    output logic        data_tx,
    output logic        data_oe,
    output logic        rx_handoff
);
    typedef enum logic [2:0] {
        idle,
        wait_resp,
        wait_crc,
        send_levels,
        send_stop
    } enc_state_e;

    enc_state_e  state;
    logic        served;        // this operation already answered
    logic [3:0]  level_cnt;     // clocks into the current bit
    logic [5:0]  bit_cnt;
    logic [31:0] tx_word;       // msb is the bit on the line

    logic [31:0] tx_src;
    logic [31:0] tx_aligned;
    logic        load_frame;
    logic [3:0]  next_cnt;
    logic [3:0]  next_level;
    logic [3:0]  cur_levels;
    logic        last_cycle;
    logic        last_bit;

    // four levels of one bit, first level in bit 3
    function automatic logic [3:0] encode_bit(input logic bit_val);
        return bit_val ? 4'b0111 : 4'b0001;    // L,H,H,H or L,L,L,H
    endfunction

    assign start = (state == idle) && cur_operation && !served;

    assign tx_src     = resp.use_crc ? {24'h000000, crc_result.rem} : 32'(resp.word);
    assign tx_aligned = tx_src << (6'd32 - resp.length);   // first data bit to msb
    assign load_frame = ((state == wait_resp) && resp.valid && !resp.use_crc) ||
                        ((state == wait_crc) && crc_result.done);

    assign next_cnt   = level_cnt + 4'd1;
    assign next_level = next_cnt / 4'(`JB_LEVEL_WIDTH);
    assign cur_levels = encode_bit(tx_word[31]);
    assign last_cycle = (level_cnt == `JB_BIT_WIDTH - 4'd1);
    assign last_bit   = (bit_cnt == resp.length - 6'd1);

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            state      <= idle;
            served     <= 1'b0;
            level_cnt  <= '0;
            bit_cnt    <= '0;
            data_tx    <= 1'b1;
            data_oe    <= 1'b0;
            rx_handoff <= 1'b0;
        end else begin
            if (!cur_operation) begin
                served <= 1'b0;                 // ready for the next operation
            end
            case (state)
                idle: begin
                    if (start) begin
                        state <= wait_resp;
                    end
                end
                wait_resp, wait_crc: begin
                    if (load_frame) begin
                        state     <= send_levels;
                        tx_word   <= tx_aligned;
                        level_cnt <= '0;
                        bit_cnt   <= '0;
                        data_tx   <= 1'b0;      // first level of bit 0
                        data_oe   <= 1'b1;
                    end else if (state == wait_resp) begin
                        if (!resp.valid) begin
                            state  <= idle;     // nothing to say, no toggle
                            served <= cur_operation;
                        end else begin
                            state <= wait_crc;
                        end
                    end
                end
                send_levels: begin
                    level_cnt <= next_cnt;
                    data_tx   <= cur_levels[2'd3 - next_level[1:0]];
                    if (last_cycle) begin
                        level_cnt <= '0;
                        data_tx   <= 1'b0;      // every bit opens low
                        bit_cnt   <= bit_cnt + 6'd1;
                        tx_word   <= tx_word << 1;
                        if (last_bit) begin
                            state <= send_stop;
                        end
                    end
                end
                send_stop: begin
                    // L,L,H then released, plus one trailing released clock
                    level_cnt <= next_cnt;
                    if (next_level >= 4'd3) begin
                        data_tx <= 1'b1;
                        data_oe <= 1'b0;
                    end else begin
                        data_tx <= (next_level == 4'd2);
                    end
                    if (level_cnt == `JB_BIT_WIDTH) begin
                        state      <= idle;
                        level_cnt  <= '0;
                        rx_handoff <= ~rx_handoff;   // hand the line back
                        served     <= cur_operation;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

//--- rtl/data_crc_unit.sv
`timescale 1ns/1ps
`include "joybus_macros.svh"

module data_crc_unit import joybus_pkg::*; (
    input  logic        sample_clk,
    input  logic        crc_reset,
    input  logic        start,
    input  logic [7:0]  crc,
    output crc_result_t result
);
    localparam logic [3:0] flush_bits = 4'd8;

    logic [3:0] shift_cnt;
    logic       busy;
    logic [7:0] next_rem;

    // one shift with a zero data bit, so feedback is just the msb
    assign next_rem = {result.rem[6:0], 1'b0} ^ (result.rem[7] ? `JB_CRC_POLY : 8'h00);

    // load seed on start, eight zero shifts, then one cycle to flag done
    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            busy        <= 1'b0;
            shift_cnt   <= '0;
            result.done <= 1'b0;
        end else if (start) begin
            result.rem  <= crc;                 // seed from the host side
            busy        <= 1'b1;
            shift_cnt   <= '0;
            result.done <= 1'b0;
        end else if (busy) begin
            if (shift_cnt == flush_bits) begin
                busy        <= 1'b0;
                result.done <= 1'b1;            // rem now holds the ack byte
            end else begin
                result.rem <= next_rem;
                shift_cnt  <= shift_cnt + 4'd1;
            end
        end
    end

endmodule

//--- rtl/response_builder.sv
`timescale 1ns/1ps
`include "joybus_macros.svh"

module response_builder import joybus_pkg::*; (
    input  logic       sample_clk,
    input  logic       crc_reset,
    input  logic       start,
    input  logic [7:0] cmd,
    input  pad_state_t pad,
    output resp_t      resp
);
    localparam logic [23:0] info_id = `JB_INFO_ID;

    jb_cmd_e cmd_code;

    assign cmd_code = jb_cmd_e'(cmd);   // unknown codes fall to default

    // word is captured once per start and held through the frame
    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            resp.valid   <= 1'b0;
            resp.use_crc <= 1'b0;
            resp.length  <= '0;
        end else if (start) begin
            resp.valid   <= 1'b1;
            resp.use_crc <= 1'b0;
            case (cmd_code)
                info, reset_info: begin
                    resp.word.info_view.pad_byte   <= 8'h00;
                    resp.word.info_view.device_id  <= info_id[23:8];
                    resp.word.info_view.aux_status <= info_id[7:0];  // no pak
                    resp.length                    <= 6'd24;
                end
                status: begin
                    resp.word.status_view <= pad;   // snapshot of buttons and stick
                    resp.length           <= 6'd32;
                end
                write: begin
                    resp.length  <= 6'd8;           // single crc byte
                    resp.use_crc <= 1'b1;
                end
                default: begin
                    resp.valid <= 1'b0;             // read and unknown codes stay silent
                end
            endcase
        end
    end

endmodule

//--- rtl/joybus_pkg.sv
package joybus_pkg;

    // command byte as received from the console
    typedef enum logic [7:0] {
        info       = 8'h00,
        status     = 8'h01,
        read       = 8'h02,
        write      = 8'h03,
        reset_info = 8'hff
    } jb_cmd_e;

    typedef struct packed {
        logic [15:0]        buttons;
        logic signed [7:0]  stick_x;
        logic signed [7:0]  stick_y;
    } pad_state_t;

    // only the low 24 bits go out for info
    typedef struct packed {
        logic [7:0]  pad_byte;    // unused top byte
        logic [15:0] device_id;
        logic [7:0]  aux_status;
    } info_view_t;

    typedef union packed {
        pad_state_t status_view;
        info_view_t info_view;
    } resp_word_u;

    // builder to encoder
    typedef struct packed {
        resp_word_u word;
        logic [5:0] length;       // data bits in the frame
        logic       use_crc;      // send crc remainder instead of word
        logic       valid;
    } resp_t;

    // crc unit to encoder
    typedef struct packed {
        logic [7:0] rem;
        logic       done;
    } crc_result_t;

endpackage

//--- include/joybus_macros.svh
`ifndef JOYBUS_MACROS_SVH
`define JOYBUS_MACROS_SVH

// line timing, in sample_clk cycles
`define JB_LEVEL_WIDTH 3'd2
`define JB_BIT_WIDTH (4'd4 * `JB_LEVEL_WIDTH)

// data CRC, x^8 term dropped
`define JB_CRC_POLY 8'h85

// answer to info and reset_info, stock controller with no pak
`define JB_INFO_ID 24'h050000

`endif
